// ==== Makefile ====
TOP  := reg_renamer_tb
SRCS := $(filter-out +%,$(shell cat flist.f))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/reg_renamer_assertions.sv ====
`timescale 1ns/1ns

module reg_renamer_assertions (
	input logic                                                clk,
	input logic                                                rst,
	input logic [renamer_pkg::NPORTS-1:0]                      alloc,
	input renamer_pkg::preg_grant_t [renamer_pkg::NPORTS-1:0]  grant,
	input logic                                                stall,
	input logic                                                restore
);

	import renamer_pkg::*;

	// ======================================================================
	// Helpers
	// ======================================================================

	function automatic logic any_grant(input preg_grant_t [NPORTS-1:0] g);
		logic any;
		any = 1'b0;
		for (int p = 0; p < NPORTS; p++)
			any = any | g[p].valid;
		return any;
	endfunction

	// Two valid ports carrying one register
	function automatic logic dup_grant(input preg_grant_t [NPORTS-1:0] g);
		logic dup;
		dup = 1'b0;
		for (int p = 0; p < NPORTS; p++)
			for (int q = p + 1; q < NPORTS; q++)
				if (g[p].valid && g[q].valid && g[p].preg == g[q].preg)
					dup = 1'b1;
		return dup;
	endfunction

	// ======================================================================
	// Properties
	// ======================================================================

	no_grant_on_stall: assert property (@(posedge clk) disable iff (rst)
		stall |-> !any_grant(grant))
		else $error("grant valid while stall is high");

	no_alloc_on_restore: assert property (@(posedge clk) disable iff (rst)
		restore |-> (alloc == '0))
		else $error("alloc request during restore");

	unique_grants: assert property (@(posedge clk) disable iff (rst)
		!dup_grant(grant))
		else $error("same register granted on two ports");

endmodule

bind reg_renamer reg_renamer_assertions checker_inst (
	.clk     (clk),
	.rst     (rst),
	.alloc   (alloc),
	.grant   (grant),
	.stall   (stall),
	.restore (restore)
);

// ==== dv/reg_renamer_tb.sv ====
`timescale 1ns/1ns

module reg_renamer_tb;

	import renamer_pkg::*;

	localparam int PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_DIRECTED = 17;
	localparam int N_RANDOM = 24;
	localparam int N_ROWS = N_DIRECTED + N_RANDOM;

	typedef enum logic [1:0] {op_alloc, op_free, op_restore, op_idle} op_t;

	// One table entry, stimulus plus what the row should produce
	typedef struct packed {
		op_t                     op;
		logic [NPORTS-1:0]       mask;
		free_req_t [NPORTS-1:0]  frees;
		logic [PREGS-1:0]        map;
		logic [3:0]              test_no;
		logic                    stall_known;
		logic                    exp_stall;
	} row_t;

	logic clk;
	logic rst;
	logic [NPORTS-1:0] alloc;
	preg_grant_t [NPORTS-1:0] grant;
	logic stall;
	free_req_t [NPORTS-1:0] frees;
	logic restore;
	logic [PREGS-1:0] restore_list;

	row_t rows [N_ROWS];
	int n_rows = 0;
	int seed = 10;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int test_rows = 0;
	int cur_test = 1;

	// Reference free map, 1 means free
	logic [PREGS-1:0] model_map;
	// Registers granted and not yet returned
	logic [PREGS-1:0] held;
	pregno_t held_q [$];
	preg_grant_t [NPORTS-1:0] exp_grant;
	logic exp_stall_m;

	reg_renamer dut (
		.clk          (clk),
		.rst          (rst),
		.alloc        (alloc),
		.grant        (grant),
		.stall        (stall),
		.frees        (frees),
		.restore      (restore),
		.restore_list (restore_list)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Ends a run that got stuck
	initial begin
		#((RESET_CYCLES + N_ROWS + 20) * PERIOD);
		$display("Watchdog expired before all table rows were applied");
		$display("Regression failed");
		$finish;
	end

	// ======================================================================
	// Table
	// ======================================================================

	function automatic free_req_t free_entry(input int preg);
		free_req_t f;
		f.valid = 1'b1;
		f.preg  = pregno_t'(preg);
		return f;
	endfunction

	task automatic add_row(input op_t op, input logic [NPORTS-1:0] mask,
			input logic [PREGS-1:0] map, input int test_no,
			input logic known, input logic exp_stall);
		row_t r;
		r = '0;
		r.op = op;
		r.mask = mask;
		r.map = map;
		r.test_no = 4'(test_no);
		r.stall_known = known;
		r.exp_stall = exp_stall;
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table();
		// Reset map, then single and four-wide requests
		add_row(op_idle, 4'b0000, '0, 1, 1'b1, 1'b0);
		add_row(op_alloc, 4'b0001, '0, 1, 1'b1, 1'b0);
		add_row(op_alloc, 4'b1111, '0, 1, 1'b1, 1'b0);
		// Sparse ports
		add_row(op_alloc, 4'b1010, '0, 2, 1'b1, 1'b0);
		// Even bank holds only 40 and 42, odd bank 41 to 49
		add_row(op_restore, 4'b0000, 64'h0002_AF00_0000_0000, 3, 1'b1, 1'b0);
		add_row(op_alloc, 4'b1111, '0, 3, 1'b1, 1'b0);
		add_row(op_alloc, 4'b0011, '0, 3, 1'b1, 1'b0);
		add_row(op_alloc, 4'b0111, '0, 3, 1'b1, 1'b1);
		add_row(op_alloc, 4'b0001, '0, 3, 1'b1, 1'b0);
		// Return 40 and 45, then ask again
		add_row(op_free, 4'b0000, '0, 4, 1'b1, 1'b0);
		rows[n_rows - 1].frees[0] = free_entry(40);
		rows[n_rows - 1].frees[2] = free_entry(45);
		add_row(op_alloc, 4'b0001, '0, 4, 1'b1, 1'b0);
		// Chosen map, then back to the reset map
		add_row(op_restore, 4'b0000, 64'h0000_0000_0000_F00F, 5, 1'b1, 1'b0);
		add_row(op_alloc, 4'b1111, '0, 5, 1'b1, 1'b0);
		add_row(op_alloc, 4'b0011, '0, 5, 1'b1, 1'b0);
		add_row(op_restore, 4'b0000, 64'hFFFF_FFFF_0000_0000, 5, 1'b1, 1'b0);
		add_row(op_alloc, 4'b0001, '0, 5, 1'b1, 1'b0);
		add_row(op_alloc, 4'b1111, '0, 5, 1'b1, 1'b0);
		// Random masks, frees are picked while running
		for (int i = 0; i < N_RANDOM; i++)
			add_row(op_alloc, 4'($random(seed)), '0, 6, 1'b0, 1'b0);
	endtask

	// Up to two previously granted registers go back
	function automatic free_req_t [NPORTS-1:0] frees_from_held();
		free_req_t [NPORTS-1:0] f;
		int n;
		int k;
		f = '0;
		n = int'($unsigned($random(seed)) % 3);
		for (int i = 0; i < n; i++) begin
			if (held_q.size() > 0) begin
				k = int'($unsigned($random(seed)) % held_q.size());
				f[i] = free_entry(int'(held_q[k]));
				held_q.delete(k);
			end
		end
		return f;
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================

	// Lowest two free per bank, interleaved, handed out in port order
	task automatic compute_expected(input logic [NPORTS-1:0] req);
		pregno_t lo [2][2];
		int n_lo [2];
		pregno_t cand [4];
		int n_cand;
		int k;
		n_lo[0] = 0;
		n_lo[1] = 0;
		n_cand = 0;
		k = 0;
		for (int b = 0; b < 2; b++) begin
			for (int r = b; r < PREGS; r += 2) begin
				if (model_map[r] && n_lo[b] < 2) begin
					lo[b][n_lo[b]] = pregno_t'(r);
					n_lo[b]++;
				end
			end
		end
		for (int s = 0; s < 2; s++) begin
			for (int b = 0; b < 2; b++) begin
				if (n_lo[b] > s) begin
					cand[n_cand] = lo[b][s];
					n_cand++;
				end
			end
		end
		exp_grant = '0;
		exp_stall_m = ($countones(req) > n_cand);
		for (int p = 0; p < NPORTS; p++) begin
			if (!exp_stall_m && req[p]) begin
				exp_grant[p].valid = 1'b1;
				exp_grant[p].preg = cand[k];
				k++;
			end
		end
	endtask

	// Next-edge update, restore wins over takes and frees
	task automatic advance_model(input row_t row);
		if (row.op == op_restore) begin
			model_map = row.map;
			held = '0;
			held_q.delete();
		end else begin
			for (int p = 0; p < NPORTS; p++) begin
				if (exp_grant[p].valid) begin
					model_map[exp_grant[p].preg] = 1'b0;
					held[exp_grant[p].preg] = 1'b1;
					held_q.push_back(exp_grant[p].preg);
				end
			end
			for (int f = 0; f < NPORTS; f++) begin
				if (row.frees[f].valid) begin
					model_map[row.frees[f].preg] = 1'b1;
					held[row.frees[f].preg] = 1'b0;
					for (int i = held_q.size() - 1; i >= 0; i--)
						if (held_q[i] == row.frees[f].preg)
							held_q.delete(i);
				end
			end
		end
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic mismatch(input string msg);
		$display("MISMATCH at %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_row(input row_t row, input int idx);
		checks++;
		if (stall !== exp_stall_m)
			mismatch($sformatf("row %0d stall %b, model %b", idx, stall, exp_stall_m));
		if (row.stall_known && stall !== row.exp_stall)
			mismatch($sformatf("row %0d stall %b, table %b", idx, stall, row.exp_stall));
		for (int p = 0; p < NPORTS; p++) begin
			if (grant[p] !== exp_grant[p])
				mismatch($sformatf("row %0d port %0d grant %b/%0d, expected %b/%0d", idx, p,
					grant[p].valid, grant[p].preg, exp_grant[p].valid, exp_grant[p].preg));
			if (grant[p].valid && held[grant[p].preg]) begin
				$display("Error at %0t: port %0d got register %0d which is still in use",
					$time, p, grant[p].preg);
				errors++;
				test_errors++;
			end
			for (int q = 0; q < p; q++) begin
				if (grant[p].valid && grant[q].valid && grant[p].preg == grant[q].preg) begin
					$display("Error at %0t: ports %0d and %0d got the same register %0d",
						$time, q, p, grant[p].preg);
					errors++;
					test_errors++;
				end
			end
		end
	endtask

	task automatic finish_test();
		if (test_rows > 0)
			$display("Test %0d done: %0d rows, %0d errors", cur_test, test_rows, test_errors);
		test_rows = 0;
		test_errors = 0;
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin
		row_t row;
		rst = 1'b1;
		alloc = '0;
		frees = '0;
		restore = 1'b0;
		restore_list = '0;
		build_table();
		model_map = {{(PREGS - NARCH){1'b1}}, {NARCH{1'b0}}};
		held = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			row = rows[i];
			if (int'(row.test_no) != cur_test) begin
				finish_test();
				cur_test = int'(row.test_no);
			end
			if (row.test_no == 4'd6)
				row.frees = frees_from_held();
			alloc = row.mask;
			frees = row.frees;
			restore = (row.op == op_restore);
			restore_list = row.map;
			compute_expected(row.mask);
			// Sample late in the low phase, outputs are settled
			#(PERIOD / 2 - 5);
			check_row(row, i);
			advance_model(row);
			test_rows++;
			@(negedge clk);
		end
		alloc = '0;
		frees = '0;
		restore = 1'b0;
		finish_test();
		$display("Summary: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== flist.f ====
verilog/renamer_pkg.sv
verilog/free_bank.sv
verilog/alloc_merge.sv
verilog/reg_renamer.sv
dv/reg_renamer_assertions.sv
dv/reg_renamer_tb.sv

// ==== verilog/alloc_merge.sv ====
`timescale 1ns/1ns

module alloc_merge (
	input  logic [renamer_pkg::NPORTS-1:0]                      alloc,
	input  renamer_pkg::bank_offer_t [renamer_pkg::NSLOTS-1:0]  offers0,
	input  renamer_pkg::bank_offer_t [renamer_pkg::NSLOTS-1:0]  offers1,
	output renamer_pkg::preg_grant_t [renamer_pkg::NPORTS-1:0]  grant,
	output logic [renamer_pkg::NSLOTS-1:0]                      take0,
	output logic [renamer_pkg::NSLOTS-1:0]                      take1,
	output logic                                                stall
);

	import renamer_pkg::*;

	// Interleaved candidates: b0s0, b1s0, b0s1, b1s1
	preg_grant_t [NCAND-1:0] cand;
	// Position of each valid candidate among the valid ones
	cnt_t [NCAND-1:0] cand_rank;
	// Position of each requesting port among the requesters
	cnt_t [NPORTS-1:0] req_rank;
	cnt_t n_cand;
	cnt_t n_req;
	// Candidate consumed this cycle, same order as cand
	logic [NCAND-1:0] taken;

	// ======================================================================
	// Candidate list
	// ======================================================================

	always_comb begin
		for (int s = 0; s < NSLOTS; s++) begin
			// Even bank, bank bit 0
			cand[2 * s].valid     = offers0[s].valid;
			cand[2 * s].preg      = pregno_t'({offers0[s].idx, 1'b0});
			// Odd bank, bank bit 1
			cand[2 * s + 1].valid = offers1[s].valid;
			cand[2 * s + 1].preg  = pregno_t'({offers1[s].idx, 1'b1});
		end
	end

	// Running count over the candidates
	always_comb begin : cand_count
		cnt_t acc;
		acc = '0;
		for (int c = 0; c < NCAND; c++) begin
			cand_rank[c] = acc;
			acc = acc + cnt_t'(cand[c].valid);
		end
		n_cand = acc;
	end

	// Running count over the requests
	always_comb begin : req_count
		cnt_t acc;
		acc = '0;
		for (int p = 0; p < NPORTS; p++) begin
			req_rank[p] = acc;
			acc = acc + cnt_t'(alloc[p]);
		end
		n_req = acc;
	end

	// Not enough offers for everyone, so nobody goes
	assign stall = (n_req > n_cand);

	// ======================================================================
	// Port assignment
	// ======================================================================

	// The k-th requester gets the k-th valid candidate
	always_comb begin
		grant = '0;
		taken = '0;
		for (int p = 0; p < NPORTS; p++) begin
			for (int c = 0; c < NCAND; c++) begin
				if (!stall && alloc[p] && cand[c].valid &&
				    (cand_rank[c] == req_rank[p])) begin
					grant[p] = cand[c];
					taken[c] = 1'b1;
				end
			end
		end
	end

	// Split consumed flags back out per bank
	always_comb begin
		for (int s = 0; s < NSLOTS; s++) begin
			take0[s] = taken[2 * s];
			take1[s] = taken[2 * s + 1];
		end
	end

endmodule

// ==== verilog/free_bank.sv ====
`timescale 1ns/1ns

module free_bank #(
	parameter int BANK_ID = 0
) (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                restore,
	input  logic [renamer_pkg::PREGS-1:0]                       restore_list,
	input  renamer_pkg::free_req_t [renamer_pkg::NPORTS-1:0]    frees,
	input  logic [renamer_pkg::NSLOTS-1:0]                      take,
	output renamer_pkg::bank_offer_t [renamer_pkg::NSLOTS-1:0]  offers
);

	import renamer_pkg::*;

	// One bit per register of this bank, 1 means free
	logic [BANK_REGS-1:0] free_map;
	logic [BANK_REGS-1:0] map_next;
	// Map with the lowest free bit knocked out
	logic [BANK_REGS-1:0] rest_map;

	// ======================================================================
	// Helpers
	// ======================================================================

	// Reset state: everything at or above NARCH is free
	function automatic logic [BANK_REGS-1:0] reset_map();
		logic [BANK_REGS-1:0] m;
		m = '0;
		for (int i = 0; i < BANK_REGS; i++) begin
			m[i] = ((2 * i + BANK_ID) >= NARCH);
		end
		return m;
	endfunction

	// Pick out this bank's interleaved half of a full map
	function automatic logic [BANK_REGS-1:0] bank_half(input logic [PREGS-1:0] full);
		logic [BANK_REGS-1:0] m;
		m = '0;
		for (int i = 0; i < BANK_REGS; i++) begin
			m[i] = full[2 * i + BANK_ID];
		end
		return m;
	endfunction

	// Priority search, lowest set bit wins
	function automatic bank_offer_t lowest_free(input logic [BANK_REGS-1:0] m);
		bank_offer_t res;
		res = '0;
		// Scan downward so the last hit is the lowest index
		for (int i = BANK_REGS - 1; i >= 0; i--) begin
			if (m[i]) begin
				res.valid = 1'b1;
				res.idx   = bank_idx_t'(i);
			end
		end
		return res;
	endfunction

	// ======================================================================
	// Map update
	// ======================================================================

	always_comb begin
		map_next = free_map;
		if (restore) begin
			// Checkpoint restore overrides takes and frees
			map_next = bank_half(restore_list);
		end else begin
			// Consumed offers leave the free list
			for (int s = 0; s < NSLOTS; s++) begin
				if (take[s] && offers[s].valid)
					map_next[offers[s].idx] = 1'b0;
			end
			// Returned tags for this bank only
			for (int f = 0; f < NPORTS; f++) begin
				if (frees[f].valid && (frees[f].preg[0] == 1'(BANK_ID)))
					map_next[bank_idx_t'(frees[f].preg >> 1)] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			free_map <= reset_map();
		else
			free_map <= map_next;
	end

	// ======================================================================
	// Offers
	// ======================================================================

	// x & (x - 1) clears the lowest set bit
	assign rest_map = free_map & (free_map - 1'b1);

	// Slot 0 is the lowest free index, slot 1 the next one up
	assign offers[0] = lowest_free(free_map);
	assign offers[1] = lowest_free(rest_map);

endmodule

// ==== verilog/reg_renamer.sv ====
`timescale 1ns/1ns

module reg_renamer (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic [renamer_pkg::NPORTS-1:0]                      alloc,
	output renamer_pkg::preg_grant_t [renamer_pkg::NPORTS-1:0]  grant,
	output logic                                                stall,
	input  renamer_pkg::free_req_t [renamer_pkg::NPORTS-1:0]    frees,
	input  logic                                                restore,
	input  logic [renamer_pkg::PREGS-1:0]                       restore_list
);

	import renamer_pkg::*;

	// Registered offers out of each bank
	bank_offer_t [NSLOTS-1:0] offers_even;
	bank_offer_t [NSLOTS-1:0] offers_odd;
	// Which of those offers the merge consumed
	logic [NSLOTS-1:0] take_even;
	logic [NSLOTS-1:0] take_odd;

	// ======================================================================
	// Banks
	// ======================================================================

	// Even register numbers
	free_bank #(
		.BANK_ID(0)
	) bank_even (
		.clk          (clk),
		.rst          (rst),
		.restore      (restore),
		.restore_list (restore_list),
		.frees        (frees),
		.take         (take_even),
		.offers       (offers_even)
	);

	// Odd register numbers
	free_bank #(
		.BANK_ID(1)
	) bank_odd (
		.clk          (clk),
		.rst          (rst),
		.restore      (restore),
		.restore_list (restore_list),
		.frees        (frees),
		.take         (take_odd),
		.offers       (offers_odd)
	);

	// Grants and stall come straight out of the merge
	alloc_merge merge (
		.alloc   (alloc),
		.offers0 (offers_even),
		.offers1 (offers_odd),
		.grant   (grant),
		.take0   (take_even),
		.take1   (take_odd),
		.stall   (stall)
	);

endmodule

// ==== verilog/renamer_pkg.sv ====
package renamer_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Physical register file
	localparam int PREGS = 64;
	// Architectural registers, mapped onto pregs 0..NARCH-1 at reset
	localparam int NARCH = 32;
	// Allocation ports and free ports
	localparam int NPORTS = 4;
	// Even and odd banks split the map in half
	localparam int BANK_REGS = PREGS / 2;
	// Offers per bank each cycle, lowest and second lowest
	localparam int NSLOTS = 2;
	// Entries in the merged candidate list
	localparam int NCAND = 2 * NSLOTS;
	// Wide enough to count 0..NPORTS
	localparam int CNT_W = $clog2(NPORTS + 1);

	// ======================================================================
	// Types
	// ======================================================================

	// Bit 0 picks the bank, bits 5:1 index into it
	typedef logic [$clog2(PREGS)-1:0] pregno_t;
	typedef logic [$clog2(BANK_REGS)-1:0] bank_idx_t;
	// Small counter for request and candidate ranks
	typedef logic [CNT_W-1:0] cnt_t;

	// One free register offered by a bank
	typedef struct packed {
		logic      valid;
		bank_idx_t idx;
	} bank_offer_t;

	// Result on one allocation port
	typedef struct packed {
		logic    valid;
		pregno_t preg;
	} preg_grant_t;

	// One register going back to the free list
	typedef struct packed {
		logic    valid;
		pregno_t preg;
	} free_req_t;

endpackage
